// File: compile.f
cce_pkg.sv
cce_regs_if.sv
cce_operand_mux.sv
cce_way_sel.sv
cce_fu_sel.sv
cce_src_sel.sv
tb_cce_src_sel.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_cce_src_sel -f compile.f -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep "^TEST OK$" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: tb_cce_src_sel.sv
// self-checking testbench for the CCE source select against a reference model with LFSR stimulus
`timescale 1ns/1ps

module tb_cce_src_sel;
  import cce_pkg::*;

  // six LCEs so sharer indices 6 and 7 fall outside the table
  localparam int num_lce         = 6;
  localparam int num_cce         = 2;
  localparam int num_wg          = 32;
  localparam int num_tests       = 6;
  localparam int cycles_per_test = 200;
  localparam int reset_cycles    = 10;
  localparam int timeout_cycles  = reset_cycles + num_tests * cycles_per_test + 100;

  logic clk_i;
  logic reset_i;

  src_sel_e                          src_a_sel;
  opd_t                              src_a_opd;
  src_sel_e                          src_b_sel;
  opd_t                              src_b_opd;
  addr_sel_e                         addr_sel;
  lce_sel_e                          lce_sel;
  way_sel_e                          way_sel;
  way_sel_e                          lru_way_sel;
  coh_sel_e                          coh_sel;
  logic [num_gpr-1:0][gpr_width-1:0] gpr;
  mshr_t                             mshr;
  logic [gpr_width-1:0]              imm;
  logic                              cce_id;
  logic                              auto_fwd;
  coh_state_e                        coh_default;
  logic [num_lce-1:0]                sh_hits;
  logic [num_lce-1:0][way_width-1:0] sh_ways;
  coh_state_e [num_lce-1:0]          sh_states;

  logic [gpr_width-1:0]    src_a;
  logic [gpr_width-1:0]    src_b;
  logic [paddr_width-1:0]  addr;
  logic                    addr_bypass;
  logic [lce_id_width-1:0] lce;
  logic [way_width-1:0]    way;
  logic [way_width-1:0]    lru_way;
  coh_state_e              state;

  logic [gpr_width-1:0]    exp_src_a;
  logic [gpr_width-1:0]    exp_src_b;
  logic [paddr_width-1:0]  exp_addr;
  logic                    exp_bypass;
  logic [lce_id_width-1:0] exp_lce;
  logic [way_width-1:0]    exp_way;
  logic [way_width-1:0]    exp_lru_way;
  coh_state_e              exp_state;

  logic [31:0] lfsr_state;
  int          cycle_count;
  int          err_count;
  int          pass_tests;
  int          fail_tests;
  int          errs_before;
  string       test_names [num_tests] = '{"registers and immediate", "flags and MSHR fields",
    "sharer lookups", "parameters", "address and LCE id", "way and coherence state"};

  cce_src_sel #(
    .num_lce_p(num_lce), .num_cce_p(num_cce), .num_way_groups_p(num_wg)
  ) dut (
    .src_a_sel_i(src_a_sel), .src_a_i(src_a_opd), .src_b_sel_i(src_b_sel), .src_b_i(src_b_opd),
    .addr_sel_i(addr_sel), .lce_sel_i(lce_sel), .way_sel_i(way_sel),
    .lru_way_sel_i(lru_way_sel), .coh_state_sel_i(coh_sel),
    .gpr_i(gpr), .mshr_i(mshr), .imm_i(imm), .cce_id_i(cce_id), .auto_fwd_msg_i(auto_fwd),
    .coh_state_default_i(coh_default), .sharers_hits_i(sh_hits), .sharers_ways_i(sh_ways),
    .sharers_coh_states_i(sh_states),
    .src_a_o(src_a), .src_b_o(src_b), .addr_o(addr), .addr_bypass_o(addr_bypass),
    .lce_o(lce), .way_o(way), .lru_way_o(lru_way), .state_o(state)
  );

  always #2 clk_i = ~clk_i;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [63:0] draw_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // raw state bits 6 and 7 read as I
  function automatic coh_state_e coh_ref(input logic [2:0] bits);
    return (bits <= 3'd5) ? coh_state_e'(bits) : e_coh_i;
  endfunction

  function automatic logic [2:0] sharer_entry(input opd_t opd);
    return gpr[opd[2:0]][2:0];
  endfunction

  function automatic logic [63:0] operand_ref(input src_sel_e sel, input opd_t opd,
                                              input opd_t sh_opd, input bit sh_en);
    logic [63:0] v;
    logic [2:0]  idx;
    logic        hit_ok;
    v = '0;
    idx = sharer_entry(sh_opd);
    hit_ok = sh_en && (int'(idx) < num_lce);
    case (sel)
      e_src_sel_gpr: v = (opd < 4'd8) ? gpr[opd[2:0]] : '0;
      e_src_sel_flag: v[0] = mshr.flags[opd];
      e_src_sel_special: begin
        case (special_e'(opd))
          e_opd_req_lce:        v = 64'(mshr.lce_id);
          e_opd_req_addr:       v = 64'(mshr.paddr);
          e_opd_req_way:        v = 64'(mshr.way_id);
          e_opd_lru_addr:       v = 64'(mshr.lru_paddr);
          e_opd_lru_way:        v = 64'(mshr.lru_way_id);
          e_opd_owner_lce:      v = 64'(mshr.owner_lce_id);
          e_opd_owner_way:      v = 64'(mshr.owner_way_id);
          e_opd_next_coh_state: v = 64'(mshr.next_coh_state);
          e_opd_flags:          v = 64'(mshr.flags);
          e_opd_flags_and_mask: v = 64'(mshr.flags & imm[15:0]);
          e_opd_sharers_hit:    v = hit_ok ? 64'(sh_hits[idx]) : '0;
          e_opd_sharers_way:    v = hit_ok ? 64'(sh_ways[idx]) : '0;
          e_opd_sharers_state:  v = hit_ok ? 64'(sh_states[idx]) : '0;
          default:              v = '0;
        endcase
      end
      e_src_sel_param: begin
        case (param_e'(opd))
          e_opd_cce_id:            v = 64'(cce_id);
          e_opd_num_lce:           v = 64'(num_lce);
          e_opd_num_cce:           v = 64'(num_cce);
          e_opd_num_wg:            v = 64'(num_wg);
          e_opd_auto_fwd_msg:      v = 64'(auto_fwd);
          e_opd_coh_state_default: v = 64'(coh_default);
          default:                 v = '0;
        endcase
      end
      e_src_sel_imm: v = imm;
      default: v = '0;
    endcase
    return v;
  endfunction

  function automatic logic [2:0] way_ref(input way_sel_e sel);
    logic [3:0] code;
    logic [2:0] idx;
    code = sel;
    idx = sharer_entry(src_a_opd);
    if (code < 4'd8) return gpr[code[2:0]][2:0];
    if (code == 4'd8) return mshr.way_id;
    if (code == 4'd9) return mshr.owner_way_id;
    if (code == 4'd10) return mshr.lru_way_id;
    if (code == 4'd11 && int'(idx) < num_lce) return sh_ways[idx];
    return '0;
  endfunction

  always_comb begin
    logic [3:0] a_code;
    logic [3:0] l_code;
    logic [3:0] c_code;
    logic [2:0] st_idx;
    a_code = addr_sel;
    l_code = lce_sel;
    c_code = coh_sel;
    st_idx = sharer_entry(src_a_opd);
    exp_src_a = operand_ref(src_a_sel, src_a_opd, src_b_opd, 1'b1);
    exp_src_b = operand_ref(src_b_sel, src_b_opd, src_a_opd, 1'b0);
    exp_addr = (a_code < 4'd8) ? gpr[a_code[2:0]][paddr_width-1:0] :
               (a_code == 4'd8) ? mshr.paddr : (a_code == 4'd9) ? mshr.lru_paddr : '0;
    exp_bypass = (a_code < 4'd8) || (a_code == 4'd10);
    exp_lce = (l_code < 4'd8) ? gpr[l_code[2:0]][2:0] :
              (l_code == 4'd8) ? mshr.lce_id : (l_code == 4'd9) ? mshr.owner_lce_id : '0;
    exp_way = way_ref(way_sel);
    exp_lru_way = way_ref(lru_way_sel);
    exp_state = e_coh_i;
    if (c_code < 4'd8) exp_state = coh_ref(gpr[c_code[2:0]][2:0]);
    else if (c_code == 4'd8) exp_state = mshr.next_coh_state;
    else if (c_code == 4'd9 && int'(st_idx) < num_lce) exp_state = sh_states[st_idx];
    else if (c_code == 4'd10) exp_state = coh_ref(imm[2:0]);
  end

  task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
    err_count++;
    $display("CHECK FAILED time=%0t signal=%s expected=%0h actual=%0h",
             $time, name, exp_v, act_v);
  endtask

  // outputs settle within the cycle and are checked at the next edge
  a_src_a: assert property (@(posedge clk_i) disable iff (reset_i) src_a == exp_src_a)
    else report_mismatch("src_a_o", $sampled(exp_src_a), $sampled(src_a));
  a_src_b: assert property (@(posedge clk_i) disable iff (reset_i) src_b == exp_src_b)
    else report_mismatch("src_b_o", $sampled(exp_src_b), $sampled(src_b));
  a_addr: assert property (@(posedge clk_i) disable iff (reset_i) addr == exp_addr)
    else report_mismatch("addr_o", 64'($sampled(exp_addr)), 64'($sampled(addr)));
  a_bypass: assert property (@(posedge clk_i) disable iff (reset_i) addr_bypass == exp_bypass)
    else report_mismatch("addr_bypass_o", 64'($sampled(exp_bypass)),
                         64'($sampled(addr_bypass)));
  a_lce: assert property (@(posedge clk_i) disable iff (reset_i) lce == exp_lce)
    else report_mismatch("lce_o", 64'($sampled(exp_lce)), 64'($sampled(lce)));
  a_way: assert property (@(posedge clk_i) disable iff (reset_i) way == exp_way)
    else report_mismatch("way_o", 64'($sampled(exp_way)), 64'($sampled(way)));
  a_lru_way: assert property (@(posedge clk_i) disable iff (reset_i) lru_way == exp_lru_way)
    else report_mismatch("lru_way_o", 64'($sampled(exp_lru_way)), 64'($sampled(lru_way)));
  a_state: assert property (@(posedge clk_i) disable iff (reset_i) state == exp_state)
    else report_mismatch("state_o", 64'($sampled(exp_state)), 64'($sampled(state)));

  task automatic drive_inputs(input int test);
    logic [num_gpr-1:0][gpr_width-1:0] g;
    mshr_t                             m;
    logic [num_lce-1:0][way_width-1:0] ways;
    coh_state_e [num_lce-1:0]          states;
    src_sel_e                          a_sel;
    src_sel_e                          b_sel;
    opd_t                              a_opd;
    opd_t                              b_opd;
    logic [3:0]                        a_code;
    logic [3:0]                        l_code;
    logic [3:0]                        w_code;
    logic [3:0]                        lru_code;
    logic [3:0]                        c_code;
    for (int i = 0; i < num_gpr; i++) g[i] = draw_bits(64);
    for (int i = 0; i < num_lce; i++) begin
      ways[i] = 3'(draw_bits(3));
      states[i] = coh_state_e'(3'(draw_bits(3) % 6));
    end
    m.lce_id = 3'(draw_bits(3));
    m.paddr = 40'(draw_bits(40));
    m.way_id = 3'(draw_bits(3));
    m.lru_paddr = 40'(draw_bits(40));
    m.lru_way_id = 3'(draw_bits(3));
    m.owner_lce_id = 3'(draw_bits(3));
    m.owner_way_id = 3'(draw_bits(3));
    m.next_coh_state = coh_state_e'(3'(draw_bits(3) % 6));
    m.flags = 16'(draw_bits(16));
    // registers with any field unless the area says otherwise
    a_sel = e_src_sel_gpr;
    b_sel = e_src_sel_gpr;
    a_opd = 4'(draw_bits(4));
    b_opd = 4'(draw_bits(4));
    a_code = 4'(e_addr_sel_zero);
    l_code = 4'(e_lce_sel_zero);
    w_code = 4'(e_way_sel_zero);
    lru_code = 4'(e_way_sel_zero);
    c_code = 4'(e_coh_sel_next_coh_state);
    case (test)
      0: begin
        a_sel = (draw_bits(1) != 0) ? e_src_sel_imm : e_src_sel_gpr;
        b_sel = (draw_bits(1) != 0) ? e_src_sel_imm : e_src_sel_gpr;
      end
      1: begin
        a_sel = (draw_bits(1) != 0) ? e_src_sel_special : e_src_sel_flag;
        b_sel = (draw_bits(1) != 0) ? e_src_sel_special : e_src_sel_flag;
        if (a_sel == e_src_sel_special) a_opd = 4'(draw_bits(4) % 10);
        if (b_sel == e_src_sel_special) b_opd = 4'(draw_bits(4) % 10);
      end
      2: begin
        a_sel = e_src_sel_special;
        b_sel = e_src_sel_special;
        a_opd = 4'(10 + draw_bits(4) % 3);
        b_opd = 4'(10 + draw_bits(4) % 3);
      end
      3: begin
        a_sel = e_src_sel_param;
        b_sel = e_src_sel_param;
        a_opd = 4'(draw_bits(4) % 6);
        b_opd = 4'(draw_bits(4) % 6);
      end
      4: begin
        a_code = 4'(draw_bits(4) % 11);
        l_code = 4'(draw_bits(4) % 11);
      end
      default: begin
        w_code = 4'(draw_bits(4) % 13);
        lru_code = 4'(draw_bits(4) % 13);
        c_code = 4'(draw_bits(4));
      end
    endcase
    gpr <= g;
    mshr <= m;
    imm <= draw_bits(64);
    cce_id <= 1'(draw_bits(1));
    auto_fwd <= 1'(draw_bits(1));
    coh_default <= coh_state_e'(3'(draw_bits(3) % 6));
    sh_hits <= num_lce'(draw_bits(num_lce));
    sh_ways <= ways;
    sh_states <= states;
    src_a_sel <= a_sel;
    src_a_opd <= a_opd;
    src_b_sel <= b_sel;
    src_b_opd <= b_opd;
    addr_sel <= addr_sel_e'(a_code);
    lce_sel <= lce_sel_e'(l_code);
    way_sel <= way_sel_e'(w_code);
    lru_way_sel <= way_sel_e'(lru_code);
    coh_sel <= coh_sel_e'(c_code);
  endtask

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    clk_i = 1'b0;
    reset_i = 1'b1;
    lfsr_state = 32'h16d010a1;
    cycle_count = 0;
    err_count = 0;
    pass_tests = 0;
    fail_tests = 0;
    src_a_sel = e_src_sel_gpr;
    src_a_opd = '0;
    src_b_sel = e_src_sel_gpr;
    src_b_opd = '0;
    addr_sel = e_addr_sel_r0;
    lce_sel = e_lce_sel_r0;
    way_sel = e_way_sel_r0;
    lru_way_sel = e_way_sel_r0;
    coh_sel = e_coh_sel_r0;
    gpr = '0;
    mshr = '0;
    imm = '0;
    cce_id = 1'b0;
    auto_fwd = 1'b0;
    coh_default = e_coh_i;
    sh_hits = '0;
    sh_ways = '0;
    sh_states = '0;
    repeat (reset_cycles) @(posedge clk_i);
    reset_i <= 1'b0;
    for (int t = 0; t < num_tests; t++) begin
      errs_before = err_count;
      repeat (cycles_per_test) begin
        @(posedge clk_i);
        drive_inputs(t);
      end
      // last drive is checked on this edge
      @(posedge clk_i);
      #1;
      if (err_count == errs_before) begin
        pass_tests++;
        $display("test %0d %s: pass", t, test_names[t]);
      end else begin
        fail_tests++;
        $display("test %0d %s: fail, %0d mismatches", t, test_names[t], err_count - errs_before);
      end
    end
    $display("tests passed %0d, tests failed %0d", pass_tests, fail_tests);
    if (err_count == 0 && fail_tests == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: cce_src_sel.sv
// top of the CCE source select datapath: plain ports in, operand and functional unit selects out
`timescale 1ns/1ps

module cce_src_sel #(
  parameter int num_lce_p        = 8,
  parameter int num_cce_p        = 1,
  parameter int num_way_groups_p = 64
) (
  input  cce_pkg::src_sel_e                                   src_a_sel_i,
  input  cce_pkg::opd_t                                       src_a_i,
  input  cce_pkg::src_sel_e                                   src_b_sel_i,
  input  cce_pkg::opd_t                                       src_b_i,
  input  cce_pkg::addr_sel_e                                  addr_sel_i,
  input  cce_pkg::lce_sel_e                                   lce_sel_i,
  input  cce_pkg::way_sel_e                                   way_sel_i,
  input  cce_pkg::way_sel_e                                   lru_way_sel_i,
  input  cce_pkg::coh_sel_e                                   coh_state_sel_i,

  input  logic [cce_pkg::num_gpr-1:0][cce_pkg::gpr_width-1:0] gpr_i,
  input  cce_pkg::mshr_t                                      mshr_i,
  input  logic [cce_pkg::gpr_width-1:0]                       imm_i,
  input  logic                                                cce_id_i,
  input  logic                                                auto_fwd_msg_i,
  input  cce_pkg::coh_state_e                                 coh_state_default_i,
  input  logic [num_lce_p-1:0]                                sharers_hits_i,
  input  logic [num_lce_p-1:0][cce_pkg::way_width-1:0]        sharers_ways_i,
  input  cce_pkg::coh_state_e [num_lce_p-1:0]                 sharers_coh_states_i,

  output logic [cce_pkg::gpr_width-1:0]                       src_a_o,
  output logic [cce_pkg::gpr_width-1:0]                       src_b_o,
  output logic [cce_pkg::paddr_width-1:0]                     addr_o,
  output logic                                                addr_bypass_o,
  output logic [cce_pkg::lce_id_width-1:0]                    lce_o,
  output logic [cce_pkg::way_width-1:0]                       way_o,
  output logic [cce_pkg::way_width-1:0]                       lru_way_o,
  output cce_pkg::coh_state_e                                 state_o
);

  cce_regs_if #(.num_lce_p(num_lce_p)) regs_if ();

  assign regs_if.gpr            = gpr_i;
  assign regs_if.mshr           = mshr_i;
  assign regs_if.imm            = imm_i;
  assign regs_if.sharers_hits   = sharers_hits_i;
  assign regs_if.sharers_ways   = sharers_ways_i;
  assign regs_if.sharers_states = sharers_coh_states_i;

  // operand A indexes sharers through operand B's register
  cce_operand_mux #(
    .num_lce_p(num_lce_p), .num_cce_p(num_cce_p),
    .num_way_groups_p(num_way_groups_p), .sharers_en_p(1'b1)
  ) u_src_a (
    .sel_i(src_a_sel_i), .opd_i(src_a_i), .sharer_opd_i(src_b_i),
    .cce_id_i(cce_id_i), .auto_fwd_msg_i(auto_fwd_msg_i),
    .coh_state_default_i(coh_state_default_i), .regs(regs_if), .operand_o(src_a_o)
  );

  cce_operand_mux #(
    .num_lce_p(num_lce_p), .num_cce_p(num_cce_p),
    .num_way_groups_p(num_way_groups_p), .sharers_en_p(1'b0)
  ) u_src_b (
    .sel_i(src_b_sel_i), .opd_i(src_b_i), .sharer_opd_i(src_a_i),
    .cce_id_i(cce_id_i), .auto_fwd_msg_i(auto_fwd_msg_i),
    .coh_state_default_i(coh_state_default_i), .regs(regs_if), .operand_o(src_b_o)
  );

  cce_way_sel #(.num_lce_p(num_lce_p)) u_way (
    .sel_i(way_sel_i), .sharer_opd_i(src_a_i), .regs(regs_if), .way_o(way_o)
  );

  cce_way_sel #(.num_lce_p(num_lce_p)) u_lru_way (
    .sel_i(lru_way_sel_i), .sharer_opd_i(src_a_i), .regs(regs_if), .way_o(lru_way_o)
  );

  cce_fu_sel #(.num_lce_p(num_lce_p)) u_fu_sel (
    .addr_sel_i(addr_sel_i), .lce_sel_i(lce_sel_i), .coh_sel_i(coh_state_sel_i),
    .sharer_opd_i(src_a_i), .regs(regs_if), .addr_o(addr_o),
    .addr_bypass_o(addr_bypass_o), .lce_o(lce_o), .state_o(state_o)
  );

endmodule

// File: cce_fu_sel.sv
// address, LCE id and coherence state selects feeding the directory and message units
`timescale 1ns/1ps

module cce_fu_sel #(
  parameter int num_lce_p = 8
) (
  input  cce_pkg::addr_sel_e               addr_sel_i,
  input  cce_pkg::lce_sel_e                lce_sel_i,
  input  cce_pkg::coh_sel_e                coh_sel_i,
  input  cce_pkg::opd_t                    sharer_opd_i,
  cce_regs_if.dst                          regs,
  output logic [cce_pkg::paddr_width-1:0]  addr_o,
  output logic                             addr_bypass_o,
  output logic [cce_pkg::lce_id_width-1:0] lce_o,
  output cce_pkg::coh_state_e              state_o
);
  import cce_pkg::*;

  logic [lce_id_width-1:0] sh_idx;

  assign sh_idx = sharer_idx(regs.gpr, sharer_opd_i);

  always_comb begin
    addr_o        = '0;
    addr_bypass_o = 1'b0;
    unique case (addr_sel_i)
      e_addr_sel_r0, e_addr_sel_r1, e_addr_sel_r2, e_addr_sel_r3,
      e_addr_sel_r4, e_addr_sel_r5, e_addr_sel_r6, e_addr_sel_r7: begin
        addr_o        = regs.gpr[gpr_sel_width'(addr_sel_i)][paddr_width-1:0];
        addr_bypass_o = 1'b1;
      end
      e_addr_sel_mshr_req: addr_o = regs.mshr.paddr;
      e_addr_sel_mshr_lru: addr_o = regs.mshr.lru_paddr;
      // constant zero needs no MSHR read either
      e_addr_sel_zero: begin
        addr_o        = '0;
        addr_bypass_o = 1'b1;
      end
      default: begin
        addr_o        = '0;
        addr_bypass_o = 1'b0;
      end
    endcase
  end

  always_comb begin
    lce_o = '0;
    unique case (lce_sel_i)
      e_lce_sel_r0, e_lce_sel_r1, e_lce_sel_r2, e_lce_sel_r3,
      e_lce_sel_r4, e_lce_sel_r5, e_lce_sel_r6, e_lce_sel_r7: begin
        lce_o = regs.gpr[gpr_sel_width'(lce_sel_i)][lce_id_width-1:0];
      end
      e_lce_sel_mshr_req:   lce_o = regs.mshr.lce_id;
      e_lce_sel_mshr_owner: lce_o = regs.mshr.owner_lce_id;
      e_lce_sel_zero:       lce_o = '0;
      default:              lce_o = '0;
    endcase
  end

  always_comb begin
    state_o = e_coh_i;
    unique case (coh_sel_i)
      e_coh_sel_r0, e_coh_sel_r1, e_coh_sel_r2, e_coh_sel_r3,
      e_coh_sel_r4, e_coh_sel_r5, e_coh_sel_r6, e_coh_sel_r7: begin
        state_o = coh_from_bits(regs.gpr[gpr_sel_width'(coh_sel_i)][coh_width-1:0]);
      end
      e_coh_sel_next_coh_state: state_o = regs.mshr.next_coh_state;
      e_coh_sel_sharer_state: begin
        if (int'(sh_idx) < num_lce_p) begin
          state_o = regs.sharers_states[sh_idx];
        end
      end
      e_coh_sel_inst_imm: state_o = coh_from_bits(regs.imm[coh_width-1:0]);
      default:            state_o = e_coh_i;
    endcase
    // MSHR and sharer states arrive typed from upstream and must stay legal
    assert (state_o inside {e_coh_i, e_coh_s, e_coh_e, e_coh_f, e_coh_m, e_coh_o})
      else $error("fu select: illegal coherence state %0d", state_o);
  end

endmodule

// File: cce_way_sel.sv
// way id select for the directory and message units, instanced for way and LRU way
`timescale 1ns/1ps

module cce_way_sel #(
  parameter int num_lce_p = 8
) (
  input  cce_pkg::way_sel_e             sel_i,
  input  cce_pkg::opd_t                 sharer_opd_i,
  cce_regs_if.dst                       regs,
  output logic [cce_pkg::way_width-1:0] way_o
);
  import cce_pkg::*;

  logic [lce_id_width-1:0] sh_idx;

  // sharer entry comes through operand A's register
  assign sh_idx = sharer_idx(regs.gpr, sharer_opd_i);

  always_comb begin
    way_o = '0;
    unique case (sel_i)
      e_way_sel_r0, e_way_sel_r1, e_way_sel_r2, e_way_sel_r3,
      e_way_sel_r4, e_way_sel_r5, e_way_sel_r6, e_way_sel_r7: begin
        way_o = regs.gpr[gpr_sel_width'(sel_i)][way_width-1:0];
      end
      e_way_sel_mshr_req:   way_o = regs.mshr.way_id;
      e_way_sel_mshr_owner: way_o = regs.mshr.owner_way_id;
      e_way_sel_mshr_lru:   way_o = regs.mshr.lru_way_id;
      e_way_sel_sh_way: begin
        if (int'(sh_idx) < num_lce_p) begin
          way_o = regs.sharers_ways[sh_idx];
        end
      end
      e_way_sel_zero:       way_o = '0;
      default:              way_o = '0;
    endcase
  end

endmodule

// File: cce_operand_mux.sv
// one ALU/branch operand chosen by source class and code, used for operand A and operand B
`timescale 1ns/1ps

module cce_operand_mux #(
  parameter int num_lce_p        = 8,
  parameter int num_cce_p        = 1,
  parameter int num_way_groups_p = 64,
  parameter bit sharers_en_p     = 1'b1
) (
  input  cce_pkg::src_sel_e             sel_i,
  input  cce_pkg::opd_t                 opd_i,
  input  cce_pkg::opd_t                 sharer_opd_i,
  input  logic                          cce_id_i,
  input  logic                          auto_fwd_msg_i,
  input  cce_pkg::coh_state_e           coh_state_default_i,
  cce_regs_if.dst                       regs,
  output logic [cce_pkg::gpr_width-1:0] operand_o
);
  import cce_pkg::*;

  logic [lce_id_width-1:0] sh_idx;
  logic                    sh_hit;
  logic [way_width-1:0]    sh_way;
  coh_state_e              sh_state;

  assign sh_idx = sharer_idx(regs.gpr, sharer_opd_i);

  // sharer lookup, zero past the last LCE
  always_comb begin
    sh_hit   = 1'b0;
    sh_way   = '0;
    sh_state = e_coh_i;
    if (sharers_en_p && (int'(sh_idx) < num_lce_p)) begin
      sh_hit   = regs.sharers_hits[sh_idx];
      sh_way   = regs.sharers_ways[sh_idx];
      sh_state = regs.sharers_states[sh_idx];
    end
  end

  always_comb begin
    operand_o = '0;
    unique case (sel_i)
      e_src_sel_gpr: begin
        if (opd_i < opd_t'(num_gpr)) begin
          operand_o = regs.gpr[opd_i[gpr_sel_width-1:0]];
        end
      end
      e_src_sel_flag: begin
        operand_o[0] = regs.mshr.flags[opd_i];
      end
      e_src_sel_special: begin
        assert (opd_i <= opd_t'(e_opd_sharers_state))
          else $error("operand mux: special code %0d out of range", opd_i);
        unique case (special_e'(opd_i))
          e_opd_req_lce:        operand_o[lce_id_width-1:0] = regs.mshr.lce_id;
          e_opd_req_addr:       operand_o[paddr_width-1:0] = regs.mshr.paddr;
          e_opd_req_way:        operand_o[way_width-1:0] = regs.mshr.way_id;
          e_opd_lru_addr:       operand_o[paddr_width-1:0] = regs.mshr.lru_paddr;
          e_opd_lru_way:        operand_o[way_width-1:0] = regs.mshr.lru_way_id;
          e_opd_owner_lce:      operand_o[lce_id_width-1:0] = regs.mshr.owner_lce_id;
          e_opd_owner_way:      operand_o[way_width-1:0] = regs.mshr.owner_way_id;
          e_opd_next_coh_state: operand_o[coh_width-1:0] = regs.mshr.next_coh_state;
          e_opd_flags:          operand_o[num_flags-1:0] = regs.mshr.flags;
          e_opd_flags_and_mask: begin
            operand_o[num_flags-1:0] = regs.mshr.flags & regs.imm[num_flags-1:0];
          end
          // operand A only, the B instance builds without sharer lookup
          e_opd_sharers_hit:    operand_o[0] = sh_hit;
          e_opd_sharers_way:    operand_o[way_width-1:0] = sh_way;
          e_opd_sharers_state:  operand_o[coh_width-1:0] = sh_state;
          default:              operand_o = '0;
        endcase
      end
      e_src_sel_param: begin
        assert (opd_i <= opd_t'(e_opd_coh_state_default))
          else $error("operand mux: param code %0d out of range", opd_i);
        unique case (param_e'(opd_i))
          e_opd_cce_id:            operand_o[0] = cce_id_i;
          e_opd_num_lce:           operand_o = gpr_width'(num_lce_p);
          e_opd_num_cce:           operand_o = gpr_width'(num_cce_p);
          e_opd_num_wg:            operand_o = gpr_width'(num_way_groups_p);
          e_opd_auto_fwd_msg:      operand_o[0] = auto_fwd_msg_i;
          e_opd_coh_state_default: operand_o[coh_width-1:0] = coh_state_default_i;
          default:                 operand_o = '0;
        endcase
      end
      e_src_sel_imm: begin
        operand_o = regs.imm;
      end
      default: begin
        operand_o = '0;
      end
    endcase
  end

endmodule

// File: cce_regs_if.sv
// register file, MSHR, immediate and sharer vectors fanned out from the top level to the muxes
`timescale 1ns/1ps

interface cce_regs_if #(
  parameter int num_lce_p = 8
);
  import cce_pkg::*;

  logic [num_gpr-1:0][gpr_width-1:0]   gpr;
  mshr_t                               mshr;
  logic [gpr_width-1:0]                imm;
  logic [num_lce_p-1:0]                sharers_hits;
  logic [num_lce_p-1:0][way_width-1:0] sharers_ways;
  coh_state_e [num_lce_p-1:0]          sharers_states;

  modport src (
    output gpr, mshr, imm, sharers_hits, sharers_ways, sharers_states
  );

  modport dst (
    input gpr, mshr, imm, sharers_hits, sharers_ways, sharers_states
  );

endinterface

// File: cce_pkg.sv
// shared widths, selector encodings and the MSHR layout for the CCE source select datapath
package cce_pkg;

  localparam int gpr_width     = 64;
  localparam int num_gpr       = 8;
  localparam int gpr_sel_width = $clog2(num_gpr);
  localparam int num_flags     = 16;
  localparam int paddr_width   = 40;
  localparam int lce_id_width  = 3;
  localparam int way_width     = 3;
  localparam int coh_width     = 3;

  typedef enum logic [coh_width-1:0] {
    e_coh_i = 3'd0,
    e_coh_s = 3'd1,
    e_coh_e = 3'd2,
    e_coh_f = 3'd3,
    e_coh_m = 3'd4,
    e_coh_o = 3'd5
  } coh_state_e;

  // operand source class from the decoded instruction
  typedef enum logic [2:0] {
    e_src_sel_gpr     = 3'd0,
    e_src_sel_flag    = 3'd1,
    e_src_sel_special = 3'd2,
    e_src_sel_param   = 3'd3,
    e_src_sel_imm     = 3'd4
  } src_sel_e;

  // register, flag, special or param number, depending on the class
  typedef logic [3:0] opd_t;

  typedef enum logic [3:0] {
    e_opd_req_lce        = 4'd0,
    e_opd_req_addr       = 4'd1,
    e_opd_req_way        = 4'd2,
    e_opd_lru_addr       = 4'd3,
    e_opd_lru_way        = 4'd4,
    e_opd_owner_lce      = 4'd5,
    e_opd_owner_way      = 4'd6,
    e_opd_next_coh_state = 4'd7,
    e_opd_flags          = 4'd8,
    e_opd_flags_and_mask = 4'd9,
    e_opd_sharers_hit    = 4'd10,
    e_opd_sharers_way    = 4'd11,
    e_opd_sharers_state  = 4'd12
  } special_e;

  typedef enum logic [3:0] {
    e_opd_cce_id            = 4'd0,
    e_opd_num_lce           = 4'd1,
    e_opd_num_cce           = 4'd2,
    e_opd_num_wg            = 4'd3,
    e_opd_auto_fwd_msg      = 4'd4,
    e_opd_coh_state_default = 4'd5
  } param_e;

  // r0..r7 share codes 0..7 in every functional unit selector
  typedef enum logic [3:0] {
    e_addr_sel_r0, e_addr_sel_r1, e_addr_sel_r2, e_addr_sel_r3,
    e_addr_sel_r4, e_addr_sel_r5, e_addr_sel_r6, e_addr_sel_r7,
    e_addr_sel_mshr_req,
    e_addr_sel_mshr_lru,
    e_addr_sel_zero
  } addr_sel_e;

  typedef enum logic [3:0] {
    e_lce_sel_r0, e_lce_sel_r1, e_lce_sel_r2, e_lce_sel_r3,
    e_lce_sel_r4, e_lce_sel_r5, e_lce_sel_r6, e_lce_sel_r7,
    e_lce_sel_mshr_req,
    e_lce_sel_mshr_owner,
    e_lce_sel_zero
  } lce_sel_e;

  typedef enum logic [3:0] {
    e_way_sel_r0, e_way_sel_r1, e_way_sel_r2, e_way_sel_r3,
    e_way_sel_r4, e_way_sel_r5, e_way_sel_r6, e_way_sel_r7,
    e_way_sel_mshr_req,
    e_way_sel_mshr_owner,
    e_way_sel_mshr_lru,
    e_way_sel_sh_way,
    e_way_sel_zero
  } way_sel_e;

  typedef enum logic [3:0] {
    e_coh_sel_r0, e_coh_sel_r1, e_coh_sel_r2, e_coh_sel_r3,
    e_coh_sel_r4, e_coh_sel_r5, e_coh_sel_r6, e_coh_sel_r7,
    e_coh_sel_next_coh_state,
    e_coh_sel_sharer_state,
    e_coh_sel_inst_imm
  } coh_sel_e;

  // 114 bits, lce_id in the top bits
  typedef struct packed {
    logic [lce_id_width-1:0] lce_id;
    logic [paddr_width-1:0]  paddr;
    logic [way_width-1:0]    way_id;
    logic [paddr_width-1:0]  lru_paddr;
    logic [way_width-1:0]    lru_way_id;
    logic [lce_id_width-1:0] owner_lce_id;
    logic [way_width-1:0]    owner_way_id;
    coh_state_e              next_coh_state;
    logic [num_flags-1:0]    flags;
  } mshr_t;

  // sharer entry number held in the register named by an operand field
  function automatic logic [lce_id_width-1:0] sharer_idx(
    input logic [num_gpr-1:0][gpr_width-1:0] gpr,
    input opd_t                              opd
  );
    return gpr[opd[gpr_sel_width-1:0]][lce_id_width-1:0];
  endfunction

  // raw bits 6 and 7 name no state and read as I
  function automatic coh_state_e coh_from_bits(input logic [coh_width-1:0] bits);
    coh_state_e st;
    if (bits > coh_width'(e_coh_o)) begin
      st = e_coh_i;
    end else begin
      st = coh_state_e'(bits);
    end
    return st;
  endfunction

endpackage
